// File: Bender.yml
package:
  name: periph_bus

sources:
  - include_dirs:
      - hw
    files:
      - hw/periph_bus_pkg.sv
      - hw/wb_master.sv
      - hw/wb_reg_slave.sv
      - hw/uart_tx.sv
      - hw/pwm_gen.sv
      - hw/periph_bus_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verification/periph_bus_chk.sv
      - verification/periph_bus_tb.sv

// File: hw/periph_bus_cfg.svh
// peripheral bus configuration: widths, slot codes, empty slots and reset values
`ifndef PERIPH_BUS_CFG_SVH
`define PERIPH_BUS_CFG_SVH

// bus widths
`define PB_DATA_W 32
`define PB_ADR_W 8

// slot codes in address bits 17:16
`define PB_SLOT_UART 2'd0
`define PB_SLOT_SPI 2'd1
`define PB_SLOT_PWM 2'd2
`define PB_SLOT_VGA 2'd3

// slots answered by the bridge itself, spi and vga
`define PB_SLOT_EMPTY 4'b1010

// register reset values
`define PB_UART_DIV_RST 16'd433
`define PB_PWM_PERIOD_RST 16'd999

`endif

// File: hw/periph_bus_pkg.sv
// peripheral bus types: processor request, wishbone request/response, register blocks
`include "periph_bus_cfg.svh"

package periph_bus_pkg;

    // single read or write from the processor side, mask of zero is a read
    typedef struct packed {
        logic [31:0]              addr;
        logic [`PB_DATA_W-1:0]    wdata;
        logic [`PB_DATA_W/8-1:0]  mask;
    } cpu_req_t;

    // shared by all slaves
    typedef struct packed {
        logic [`PB_ADR_W-1:0]     adr;
        logic [`PB_DATA_W-1:0]    dat;
        logic                     we;
        logic [`PB_DATA_W/8-1:0]  sel;
        logic                     stb;
    } wb_req_t;

    typedef struct packed {
        logic                     ack;
        logic [`PB_DATA_W-1:0]    dat;
    } wb_rsp_t;

    // word 2 in the msbs, word 0 in the lsbs
    typedef struct packed {
        logic [30:0] ctrl_rsvd;
        logic        start;
        logic [15:0] div_rsvd;
        logic [15:0] div;
        logic [23:0] data_rsvd;
        logic [7:0]  data;
    } uart_regs_t;

    typedef struct packed {
        logic [30:0] ctrl_rsvd;
        logic        enable;
        logic [15:0] duty_rsvd;
        logic [15:0] duty;
        logic [15:0] period_rsvd;
        logic [15:0] period;
    } pwm_regs_t;

endpackage

// File: hw/periph_bus_top.sv
// peripheral bus top: wishbone bridge, register slaves, uart transmitter and pwm
`timescale 1ns/1ps
`include "periph_bus_cfg.svh"

module periph_bus_top (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  periph_bus_pkg::cpu_req_t    cpu_req_i,
    input  logic                        cpu_sel_i,
    output logic [`PB_DATA_W-1:0]       cpu_rdata_o,
    output logic                        cpu_stall_o,
    output logic                        uart_tx_o,
    output logic                        pwm_o
);

    localparam periph_bus_pkg::uart_regs_t UART_RST = '{
        div:     `PB_UART_DIV_RST,
        default: '0
    };
    localparam periph_bus_pkg::pwm_regs_t PWM_RST = '{
        period:  `PB_PWM_PERIOD_RST,
        default: '0
    };

    periph_bus_pkg::wb_req_t         wb_req;
    logic [3:0]                      cyc;
    periph_bus_pkg::wb_rsp_t [3:0]   rsp;
    periph_bus_pkg::uart_regs_t      uart_regs;
    periph_bus_pkg::pwm_regs_t       pwm_regs;
    logic                            uart_wr;
    logic                            pwm_wr;
    logic [31:0]                     uart_status;
    logic [31:0]                     pwm_status;

    // unpopulated slots, masked off inside the bridge
    assign rsp[`PB_SLOT_SPI] = '0;
    assign rsp[`PB_SLOT_VGA] = '0;

    wb_master master_u (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cpu_req_i   (cpu_req_i),
        .cpu_sel_i   (cpu_sel_i),
        .cpu_rdata_o (cpu_rdata_o),
        .cpu_stall_o (cpu_stall_o),
        .wb_req_o    (wb_req),
        .cyc_o       (cyc),
        .rsp_i       (rsp)
    );

    wb_reg_slave #(
        .reg_t   (periph_bus_pkg::uart_regs_t),
        .RST_VAL (UART_RST)
    ) uart_regs_u (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_req_i (wb_req),
        .cyc_i    (cyc[`PB_SLOT_UART]),
        .rsp_o    (rsp[`PB_SLOT_UART]),
        .regs_o   (uart_regs),
        .wr_o     (uart_wr),
        .status_i (uart_status)
    );

    wb_reg_slave #(
        .reg_t   (periph_bus_pkg::pwm_regs_t),
        .RST_VAL (PWM_RST)
    ) pwm_regs_u (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .wb_req_i (wb_req),
        .cyc_i    (cyc[`PB_SLOT_PWM]),
        .rsp_o    (rsp[`PB_SLOT_PWM]),
        .regs_o   (pwm_regs),
        .wr_o     (pwm_wr),
        .status_i (pwm_status)
    );

    uart_tx uart_u (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .regs_i   (uart_regs),
        .wr_i     (uart_wr),
        .status_o (uart_status),
        .tx_o     (uart_tx_o)
    );

    pwm_gen pwm_u (
        .clk_i    (clk_i),
        .rst_i    (rst_i),
        .regs_i   (pwm_regs),
        .wr_i     (pwm_wr),
        .status_o (pwm_status),
        .pwm_o    (pwm_o)
    );

endmodule

// File: hw/pwm_gen.sv
// pwm generator, free-running counter compared against a programmable duty
`timescale 1ns/1ps

module pwm_gen (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  periph_bus_pkg::pwm_regs_t   regs_i,
    input  logic                        wr_i,
    output logic [31:0]                 status_o,
    output logic                        pwm_o
);

    logic [15:0] cnt_q;
    logic [15:0] cnt_d;
    logic        pwm_q;

    // control write restarts the period, disable parks at zero
    always_comb begin
        if (wr_i || !regs_i.enable) begin
            cnt_d = '0;
        end else if (cnt_q == regs_i.period) begin
            cnt_d = '0;
        end else begin
            cnt_d = cnt_q + 16'd1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
            pwm_q <= 1'b0;
        end else begin
            cnt_q <= cnt_d;
            // output lines up with the counter value it is derived from
            pwm_q <= regs_i.enable & (cnt_d < regs_i.duty);
        end
    end

    assign status_o = {16'b0, cnt_q};
    assign pwm_o    = pwm_q;

endmodule

// File: hw/uart_tx.sv
// uart transmitter, 8N1 frames timed by a programmable baud divisor
`timescale 1ns/1ps

module uart_tx (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  periph_bus_pkg::uart_regs_t  regs_i,
    input  logic                        wr_i,
    output logic [31:0]                 status_o,
    output logic                        tx_o
);

    logic        busy_q;
    logic        tx_q;
    logic [3:0]  bit_cnt_q;
    logic [15:0] div_cnt_q;
    logic [15:0] div_q;
    // data bits then the stop bit, shifted out lsb first
    logic [8:0]  shreg_q;
    logic        start_go;
    logic        bit_end;
    logic        last_bit;

    // start requests while busy are dropped
    assign start_go = wr_i & regs_i.start & ~busy_q;
    assign bit_end  = busy_q & (div_cnt_q == div_q);
    assign last_bit = (bit_cnt_q == 4'd9);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q    <= 1'b0;
            tx_q      <= 1'b1;
            bit_cnt_q <= '0;
            div_cnt_q <= '0;
        end else if (start_go) begin
            busy_q    <= 1'b1;
            tx_q      <= 1'b0;
            bit_cnt_q <= '0;
            div_cnt_q <= '0;
        end else if (bit_end) begin
            div_cnt_q <= '0;
            if (last_bit) begin
                busy_q <= 1'b0;
                tx_q   <= 1'b1;
            end else begin
                bit_cnt_q <= bit_cnt_q + 4'd1;
                tx_q      <= shreg_q[0];
            end
        end else if (busy_q) begin
            div_cnt_q <= div_cnt_q + 16'd1;
        end
    end

    // frame payload, divisor held for the whole frame
    always_ff @(posedge clk_i) begin
        if (start_go) begin
            shreg_q <= {1'b1, regs_i.data};
            div_q   <= regs_i.div;
        end else if (bit_end && !last_bit) begin
            shreg_q <= {1'b1, shreg_q[8:1]};
        end
    end

    assign status_o = {31'b0, busy_q};
    assign tx_o     = tx_q;

endmodule

// File: hw/wb_master.sv
// wishbone classic master bridge: processor request to bus cycle, slot decode and stall
`timescale 1ns/1ps
`include "periph_bus_cfg.svh"

module wb_master (
    input  logic                            clk_i,
    input  logic                            rst_i,

    // processor side
    input  periph_bus_pkg::cpu_req_t        cpu_req_i,
    input  logic                            cpu_sel_i,
    output logic [`PB_DATA_W-1:0]           cpu_rdata_o,
    output logic                            cpu_stall_o,

    // wishbone side
    output periph_bus_pkg::wb_req_t         wb_req_o,
    output logic [3:0]                      cyc_o,
    input  periph_bus_pkg::wb_rsp_t [3:0]   rsp_i
);

    localparam logic [3:0] EMPTY_MASK = `PB_SLOT_EMPTY;

    typedef enum logic {
        ST_IDLE = 1'b0,
        ST_BUS  = 1'b1
    } state_t;

    state_t     state_q;
    state_t     state_d;
    logic       sel_q;
    logic [1:0] slot;
    logic       slot_empty;
    logic       in_bus;
    logic       ack;

    // slot field of the processor address
    assign slot       = cpu_req_i.addr[17:16];
    assign slot_empty = EMPTY_MASK[slot];
    assign in_bus     = (state_q == ST_BUS);

    // empty slots get a local ack as soon as the bus state is reached
    assign ack         = slot_empty ? in_bus : rsp_i[slot].ack;
    assign cpu_rdata_o = slot_empty ? '0 : rsp_i[slot].dat;

    // stall on the select edge, then until the ack
    assign cpu_stall_o = (cpu_sel_i & ~sel_q) | (in_bus & ~ack);

    // request passes straight through
    assign wb_req_o.adr = cpu_req_i.addr[`PB_ADR_W-1:0];
    assign wb_req_o.dat = cpu_req_i.wdata;
    assign wb_req_o.we  = |cpu_req_i.mask;
    assign wb_req_o.sel = cpu_req_i.mask;
    assign wb_req_o.stb = in_bus;

    // only the addressed slot sees cyc
    always_comb begin
        cyc_o       = '0;
        cyc_o[slot] = in_bus;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cpu_sel_i) begin
                    state_d = ST_BUS;
                end
            end
            ST_BUS: begin
                if (ack) begin
                    state_d = ST_IDLE;
                end
            end
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_IDLE;
            sel_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            sel_q   <= cpu_sel_i;
        end
    end

endmodule

// File: hw/wb_reg_slave.sv
// generic wishbone register slave with byte-select writes and a read-only status word
`timescale 1ns/1ps
`include "periph_bus_cfg.svh"

module wb_reg_slave #(
    parameter type  reg_t   = logic [3*`PB_DATA_W-1:0],
    parameter reg_t RST_VAL = '0
) (
    input  logic                        clk_i,
    input  logic                        rst_i,
    input  periph_bus_pkg::wb_req_t     wb_req_i,
    input  logic                        cyc_i,
    output periph_bus_pkg::wb_rsp_t     rsp_o,
    output reg_t                        regs_o,
    output logic                        wr_o,
    input  logic [`PB_DATA_W-1:0]       status_i
);

    localparam int NWORDS = $bits(reg_t) / `PB_DATA_W;
    localparam int NBYTES = `PB_DATA_W / 8;

    logic [NWORDS-1:0][`PB_DATA_W-1:0] regs_q;
    logic                              ack_q;
    logic                              wr_q;
    logic [`PB_DATA_W-1:0]             dat_q;
    logic [`PB_DATA_W-1:0]             rd_word;
    logic [1:0]                        idx;
    logic                              hit;
    logic                              wr_hit;

    assign idx    = wb_req_i.adr[3:2];
    // one ack per cycle, the held strobe is not taken twice
    assign hit    = cyc_i & wb_req_i.stb & ~ack_q;
    assign wr_hit = hit & wb_req_i.we & (idx != 2'd3) & (int'(idx) < NWORDS);

    // word 3 always reads the peripheral status
    always_comb begin
        if (idx == 2'd3) begin
            rd_word = status_i;
        end else if (int'(idx) < NWORDS) begin
            rd_word = regs_q[idx];
        end else begin
            rd_word = '0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            regs_q <= RST_VAL;
            ack_q  <= 1'b0;
            wr_q   <= 1'b0;
        end else begin
            ack_q <= hit;
            wr_q  <= wr_hit & (idx == 2'd2);
            if (wr_hit) begin
                for (int b = 0; b < NBYTES; b++) begin
                    if (wb_req_i.sel[b]) begin
                        regs_q[idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
                    end
                end
            end
        end
    end

    // read data captured with the ack
    always_ff @(posedge clk_i) begin
        if (hit) begin
            dat_q <= rd_word;
        end
    end

    assign rsp_o.ack = ack_q;
    assign rsp_o.dat = dat_q;
    assign regs_o    = reg_t'(regs_q);
    assign wr_o      = wr_q;

endmodule

// File: periph_bus.f
+incdir+hw
hw/periph_bus_pkg.sv
hw/wb_master.sv
hw/wb_reg_slave.sv
hw/uart_tx.sv
hw/pwm_gen.sv
hw/periph_bus_top.sv
verification/periph_bus_chk.sv
verification/periph_bus_tb.sv

// File: verification/periph_bus_chk.sv
// wishbone bridge checker: cyc exclusivity, strobe, stall release and ack placement
`timescale 1ns/1ps

module periph_bus_chk (
    input logic                     clk_i,
    input logic                     rst_i,
    input logic                     cpu_sel_i,
    input logic                     cpu_stall_i,
    input periph_bus_pkg::wb_req_t  wb_req_i,
    input logic [3:0]               cyc_i,
    input logic                     ack_i
);

    int unsigned assert_fails = 0;

    assert property (@(posedge clk_i) disable iff (rst_i) $onehot0(cyc_i))
    else begin
        assert_fails++;
        $error("more than one cyc line high: %b", cyc_i);
    end

    assert property (@(posedge clk_i) disable iff (rst_i) wb_req_i.stb |-> $onehot(cyc_i))
    else begin
        assert_fails++;
        $error("stb high without exactly one cyc line: %b", cyc_i);
    end

    // stall may only drop on the ack or once the select is gone
    assert property (@(posedge clk_i) disable iff (rst_i)
        $fell(cpu_stall_i) |-> (ack_i || !cpu_sel_i))
    else begin
        assert_fails++;
        $error("stall dropped without an ack while select was high");
    end

    assert property (@(posedge clk_i) disable iff (rst_i) ack_i |-> wb_req_i.stb)
    else begin
        assert_fails++;
        $error("ack seen while stb was low");
    end

endmodule

bind wb_master periph_bus_chk chk_u (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .cpu_sel_i   (cpu_sel_i),
    .cpu_stall_i (cpu_stall_o),
    .wb_req_i    (wb_req_o),
    .cyc_i       (cyc_o),
    .ack_i       (ack)
);

// File: verification/periph_bus_tb.sv
// testbench for the peripheral bus covering register access, latency, uart frames and pwm duty
`timescale 1ns/1ps
`include "periph_bus_cfg.svh"

module periph_bus_tb;

    localparam int CLK_NS      = 10;
    localparam int REG_WRITES  = 24;
    localparam int UART_FRAMES = 4;
    localparam int DIV_MAX     = 5;
    localparam int PWM_RUNS    = 4;
    localparam int PERIOD_MAX  = 40;
    localparam int ACCESS      = 4;
    localparam int START_LIMIT = 40;
    localparam int EST_CYCLES  = 40 + (12 + 2 * REG_WRITES) * ACCESS
        + UART_FRAMES * (5 * ACCESS + 11 * (DIV_MAX + 1))
        + (PWM_RUNS + 1) * (3 * ACCESS + PERIOD_MAX + 1);
    // summed test length plus 20 percent
    localparam int WATCHDOG_NS = EST_CYCLES * CLK_NS * 12 / 10;
    localparam logic [3:0] EMPTY_MASK = `PB_SLOT_EMPTY;
    localparam int KIND_WORD   = 0;
    localparam int KIND_BIT    = 1;
    localparam int KIND_COUNT  = 2;

    logic                       clk_i;
    logic                       rst_i;
    periph_bus_pkg::cpu_req_t   cpu_req_i;
    logic                       cpu_sel_i;
    logic [`PB_DATA_W-1:0]      cpu_rdata_o;
    logic                       cpu_stall_o;
    logic                       uart_tx_o;
    logic                       pwm_o;

    // model copy of both register blocks indexed by slot and word
    logic [`PB_DATA_W-1:0]      model_regs [4][3];
    int                         res_kind [$];
    string                      res_name [$];
    logic [`PB_DATA_W-1:0]      res_exp [$];
    logic [`PB_DATA_W-1:0]      res_got [$];
    int                         errors = 0;
    int                         checks = 0;
    int                         tests = 0;
    int                         test_base = 0;

    periph_bus_top dut_i (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .cpu_req_i   (cpu_req_i),
        .cpu_sel_i   (cpu_sel_i),
        .cpu_rdata_o (cpu_rdata_o),
        .cpu_stall_o (cpu_stall_o),
        .uart_tx_o   (uart_tx_o),
        .pwm_o       (pwm_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_NS / 2) clk_i = ~clk_i;
    end

    function automatic logic [31:0] word_addr(input logic [1:0] slot, input logic [1:0] word);
        return {14'b0, slot, 12'h000, word, 2'b00};
    endfunction

    function automatic logic [`PB_DATA_W-1:0] ref_reg_word(input logic [`PB_DATA_W-1:0] old,
            input logic [`PB_DATA_W-1:0] wdata, input logic [`PB_DATA_W/8-1:0] mask);
        logic [`PB_DATA_W-1:0] word;
        word = old;
        for (int b = 0; b < `PB_DATA_W / 8; b++) begin
            if (mask[b]) begin
                word[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return word;
    endfunction

    // frame bit 0 is the start bit and leaves the line first
    function automatic logic [9:0] ref_uart_frame(input logic [7:0] data);
        return {1'b1, data, 1'b0};
    endfunction

    function automatic int ref_pwm_high_count(input logic enable, input int period,
                                              input int duty);
        if (!enable) begin
            return 0;
        end
        return (duty < period + 1) ? duty : period + 1;
    endfunction

    task automatic check_word(input string name, input logic [`PB_DATA_W-1:0] exp,
                              input logic [`PB_DATA_W-1:0] got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic check_count(input string name, input int unsigned exp, input int unsigned got);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch %s: expected %h, got %h", name, exp, got);
        end
    endtask

    task automatic queue_result(input int kind, input string name,
                                input logic [`PB_DATA_W-1:0] exp,
                                input logic [`PB_DATA_W-1:0] got);
        res_kind.push_back(kind);
        res_name.push_back(name);
        res_exp.push_back(exp);
        res_got.push_back(got);
    endtask

    // results are pushed on rising edges and compared on falling edges
    initial begin : compare
        forever begin
            @(negedge clk_i);
            while (res_kind.size() > 0) begin
                case (res_kind[0])
                    KIND_WORD: check_word(res_name[0], res_exp[0], res_got[0]);
                    KIND_BIT:  check_bit(res_name[0], res_exp[0][0], res_got[0][0]);
                    default:   check_count(res_name[0], res_exp[0], res_got[0]);
                endcase
                res_kind.delete(0);
                res_name.delete(0);
                res_exp.delete(0);
                res_got.delete(0);
            end
        end
    end

    task automatic finish_test(input string name);
        @(posedge clk_i);
        while (res_kind.size() != 0) begin
            @(posedge clk_i);
        end
        tests++;
        if (errors == test_base) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - test_base);
        end
        test_base = errors;
    endtask

    task automatic bus_access(input logic [31:0] addr, input logic [`PB_DATA_W-1:0] wdata,
                              input logic [`PB_DATA_W/8-1:0] mask,
                              output logic [`PB_DATA_W-1:0] rdata, output int lat);
        @(posedge clk_i);
        cpu_req_i.addr  <= addr;
        cpu_req_i.wdata <= wdata;
        cpu_req_i.mask  <= mask;
        cpu_sel_i       <= 1'b1;
        lat = 0;
        @(posedge clk_i);
        // done in the first cycle with select high and no stall
        while (cpu_stall_o) begin
            lat++;
            @(posedge clk_i);
        end
        rdata = cpu_rdata_o;
        cpu_sel_i <= 1'b0;
    endtask

    task automatic bus_write(input logic [1:0] slot, input logic [1:0] word,
                             input logic [`PB_DATA_W-1:0] wdata,
                             input logic [`PB_DATA_W/8-1:0] mask);
        logic [`PB_DATA_W-1:0] rdata;
        int                    lat;
        bus_access(word_addr(slot, word), wdata, mask, rdata, lat);
        if (!EMPTY_MASK[slot] && word != 2'd3) begin
            model_regs[slot][word] = ref_reg_word(model_regs[slot][word], wdata, mask);
        end
    endtask

    task automatic bus_read(input logic [1:0] slot, input logic [1:0] word,
                            output logic [`PB_DATA_W-1:0] rdata, output int lat);
        bus_access(word_addr(slot, word), '0, '0, rdata, lat);
    endtask

    // samples the line in the middle of each bit once the start bit shows
    task automatic capture_uart_frame(input int div, output logic [9:0] frame);
        int waited;
        waited = 0;
        frame = '0;
        @(posedge clk_i);
        while (uart_tx_o !== 1'b0) begin
            waited++;
            if (waited > START_LIMIT) begin
                errors++;
                $display("no start bit on uart_tx_o within %0d cycles", START_LIMIT);
                return;
            end
            @(posedge clk_i);
        end
        repeat ((div + 1) / 2) @(posedge clk_i);
        for (int i = 0; i < 10; i++) begin
            frame[i] = uart_tx_o;
            if (i < 9) begin
                repeat (div + 1) @(posedge clk_i);
            end
        end
    endtask

    task automatic count_pwm_high(input int cycles, output int high);
        high = 0;
        repeat (cycles) begin
            @(posedge clk_i);
            if (pwm_o === 1'b1) begin
                high++;
            end
        end
    endtask

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the tests did not complete", WATCHDOG_NS);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [`PB_DATA_W-1:0] rdata;
        logic [`PB_DATA_W-1:0] wdata;
        logic [9:0]            frame;
        logic [7:0]            tx_byte;
        logic [1:0]            slot;
        logic [1:0]            word;
        logic [3:0]            mask;
        int                    lat;
        int                    div;
        int                    period;
        int                    duty;
        int                    high;
        void'($urandom(32'habc5_ea88));
        rst_i     = 1'b1;
        cpu_sel_i = 1'b0;
        cpu_req_i = '0;
        foreach (model_regs[s, w]) begin
            model_regs[s][w] = '0;
        end
        model_regs[`PB_SLOT_UART][1] = 32'(`PB_UART_DIV_RST);
        model_regs[`PB_SLOT_PWM][0]  = 32'(`PB_PWM_PERIOD_RST);
        repeat (5) @(posedge clk_i);
        rst_i <= 1'b0;

        @(posedge clk_i);
        queue_result(KIND_BIT, "cpu_stall_o", 32'd0, {31'b0, cpu_stall_o});
        queue_result(KIND_BIT, "pwm_o", 32'd0, {31'b0, pwm_o});
        queue_result(KIND_BIT, "uart_tx_o", 32'd1, {31'b0, uart_tx_o});
        finish_test("reset");

        for (int s = 0; s < 2; s++) begin
            slot = (s == 0) ? `PB_SLOT_UART : `PB_SLOT_PWM;
            for (int w = 0; w < 3; w++) begin
                bus_read(slot, 2'(w), rdata, lat);
                queue_result(KIND_WORD, $sformatf("cpu_rdata_o slot %0d word %0d", slot, w),
                             model_regs[slot][w], rdata);
            end
        end
        repeat (REG_WRITES) begin
            slot  = ($urandom_range(0, 1) == 0) ? `PB_SLOT_UART : `PB_SLOT_PWM;
            word  = 2'($urandom_range(0, 2));
            wdata = $urandom;
            mask  = 4'($urandom_range(1, 15));
            // keep the uart start bit clear so no frame is launched here
            if (slot == `PB_SLOT_UART && word == 2'd2) begin
                wdata[0] = 1'b0;
            end
            bus_write(slot, word, wdata, mask);
            bus_read(slot, word, rdata, lat);
            queue_result(KIND_WORD, $sformatf("cpu_rdata_o slot %0d word %0d", slot, word),
                         model_regs[slot][word], rdata);
        end
        finish_test("registers");

        for (int s = 0; s < 4; s++) begin
            bus_read(2'(s), 2'd0, rdata, lat);
            queue_result(KIND_COUNT, $sformatf("cpu_stall_o read latency slot %0d", s),
                         EMPTY_MASK[s] ? 32'd1 : 32'd2, 32'(lat));
            if (EMPTY_MASK[s]) begin
                queue_result(KIND_WORD, $sformatf("cpu_rdata_o slot %0d", s), '0, rdata);
            end
        end
        bus_access(word_addr(`PB_SLOT_SPI, 2'd0), $urandom, 4'hf, rdata, lat);
        queue_result(KIND_COUNT, "cpu_stall_o write latency spi slot", 32'd1, 32'(lat));
        finish_test("latency");

        repeat (UART_FRAMES) begin
            div     = $urandom_range(2, DIV_MAX);
            tx_byte = 8'($urandom);
            bus_write(`PB_SLOT_UART, 2'd0, {24'h0, tx_byte}, 4'h1);
            bus_write(`PB_SLOT_UART, 2'd1, div, 4'h3);
            bus_write(`PB_SLOT_UART, 2'd2, 32'h1, 4'h1);
            fork
                capture_uart_frame(div, frame);
                begin
                    bus_read(`PB_SLOT_UART, 2'd3, rdata, lat);
                    queue_result(KIND_BIT, "cpu_rdata_o uart busy during frame", 32'd1,
                                 {31'b0, rdata[0]});
                end
            join
            queue_result(KIND_WORD, "uart_tx_o frame", {22'b0, ref_uart_frame(tx_byte)},
                         {22'b0, frame});
            repeat (div + 1) @(posedge clk_i);
            bus_read(`PB_SLOT_UART, 2'd3, rdata, lat);
            queue_result(KIND_BIT, "cpu_rdata_o uart busy after frame", 32'd0,
                         {31'b0, rdata[0]});
        end
        finish_test("uart");

        repeat (PWM_RUNS) begin
            period = $urandom_range(1, PERIOD_MAX);
            duty   = $urandom_range(0, PERIOD_MAX + 2);
            bus_write(`PB_SLOT_PWM, 2'd0, period, 4'h3);
            bus_write(`PB_SLOT_PWM, 2'd1, duty, 4'h3);
            bus_write(`PB_SLOT_PWM, 2'd2, 32'h1, 4'h1);
            count_pwm_high(period + 1, high);
            queue_result(KIND_COUNT, "pwm_o high cycles",
                         32'(ref_pwm_high_count(1'b1, period, duty)), 32'(high));
        end
        bus_write(`PB_SLOT_PWM, 2'd2, 32'h0, 4'h1);
        count_pwm_high(period + 1, high);
        queue_result(KIND_COUNT, "pwm_o high cycles disabled",
                     32'(ref_pwm_high_count(1'b0, period, duty)), 32'(high));
        finish_test("pwm");

        errors = errors + int'(dut_i.master_u.chk_u.assert_fails);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
